// File: logic/input_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module input_decoder #(
	parameter int MASS_SHIFT = 2
) (
	input logic clock,
	input logic reset,
	input logic [31:0] controller,
	input logic [4:0] contact,
	intent_if.source intent
);

	logic [link_pkg::JOY_W-1:0] joy_x, joy_y;
	logic signed [8:0] centred_x;
	logic press, press_prev;
	logic jump_used;
	logic fire, grounded;

	assign joy_x = controller[link_pkg::JOY_X_LSB +: link_pkg::JOY_W];
	assign joy_y = controller[link_pkg::JOY_Y_LSB +: link_pkg::JOY_W];
	assign centred_x = $signed({1'b0, joy_x}) - 9'sd128; // -128 to 127

	// Button or stick flicked up
	assign press = controller[link_pkg::JUMP_BIT] | (joy_y >= link_pkg::JUMP_MIN);
	assign grounded = contact[link_pkg::WALL_DOWN] | contact[link_pkg::PLATFORM_DOWN];

	// Rising press, one jump per landing
	assign fire = press & ~press_prev & ~jump_used;

	assign intent.jump_vel = physics_pkg::JUMP_IMPULSE >>> MASS_SHIFT;

	always_ff @(posedge clock) begin
		if (reset) begin
			press_prev <= 1'b0;
			jump_used <= 1'b0;
			intent.jump <= 1'b0;
		end else begin
			press_prev <= press;
			intent.jump <= fire;
			if (fire)
				jump_used <= 1'b1;
			else if (grounded)
				jump_used <= 1'b0; // Re-arm on contact
		end
	end

	// Stick scaled into fraction units, lighter players move faster
	always_ff @(posedge clock) begin
		intent.move_x <= (physics_pkg::vel_t'(centred_x) <<< 8) >>> MASS_SHIFT;
		intent.drop_through <= joy_y <= link_pkg::DROP_MAX;
	end

endmodule

`default_nettype wire

// File: logic/intent_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded movement intent, decoder to integrator
interface intent_if;
	physics_pkg::vel_t move_x;   // Scaled stick X
	logic jump;                  // One-cycle strobe
	physics_pkg::vel_t jump_vel; // Scaled impulse
	logic drop_through;          // Stick held down

	modport source (output move_x, jump, jump_vel, drop_through);
	modport sink (input move_x, jump, jump_vel, drop_through);
endinterface

`default_nettype wire

// File: logic/knock_if.sv
`timescale 1ns/1ps
`default_nettype none

// Scaled knockback, knockback unit to integrator
interface knock_if;
	logic kick;                // One-cycle strobe
	physics_pkg::vel_t kick_x;
	physics_pkg::vel_t kick_y;
	logic busy;                // Request accepted, not yet released

	modport source (output kick, kick_x, kick_y, busy);
	modport sink (input kick, kick_x, kick_y, busy);
endinterface

`default_nettype wire

// File: logic/knockback_calc.sv
`timescale 1ns/1ps
`default_nettype none

module knockback_calc (
	input logic clock,
	input logic reset,
	input logic knock_req,
	input logic [31:0] knockback,
	input logic [15:0] damage,
	output logic knock_ack,
	knock_if.source kick
);

	localparam logic [7:0] DIVISOR = 8'd100;
	localparam logic [3:0] LAST_STEP = 4'd15; // Two quotient bits per step

	link_pkg::kb_state_e state;
	logic [3:0] step;
	logic [15:0] mag_x, mag_y;
	logic [16:0] scale;
	logic [31:0] prod_x, prod_y;
	logic neg_x, neg_y;
	logic [39:0] acc_x, acc_y; // Remainder over dividend and quotient
	logic [39:0] acc_x_next, acc_y_next;
	physics_pkg::vel_t quot_x, quot_y;

	// One restoring step, quotient bit shifts in at the bottom
	function automatic logic [39:0] div_step(input logic [39:0] acc);
		logic [7:0] trial;
		logic fits;
		trial = {acc[38:32], acc[31]};
		fits = trial >= DIVISOR;
		div_step = {fits ? trial - DIVISOR : trial, acc[30:0], fits};
	endfunction

	// Magnitudes first, signs go back on after the divide
	assign mag_x = knockback[31] ? ~knockback[31:16] + 16'd1 : knockback[31:16];
	assign mag_y = knockback[15] ? ~knockback[15:0] + 16'd1 : knockback[15:0];
	assign scale = {1'b0, damage} + 17'd100;
	assign prod_x = {16'd0, mag_x} * {15'd0, scale};
	assign prod_y = {16'd0, mag_y} * {15'd0, scale};

	assign acc_x_next = div_step(div_step(acc_x));
	assign acc_y_next = div_step(div_step(acc_y));
	assign quot_x = acc_x_next[physics_pkg::VEL_W-1:0];
	assign quot_y = acc_y_next[physics_pkg::VEL_W-1:0];

	assign kick.kick = state == link_pkg::kb_hold_ack;
	assign kick.busy = state != link_pkg::kb_idle;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= link_pkg::kb_idle;
			step <= 4'd0;
			knock_ack <= 1'b0;
		end else begin
			case (state)
				link_pkg::kb_idle: begin
					step <= 4'd0;
					if (knock_req)
						state <= link_pkg::kb_divide;
				end
				link_pkg::kb_divide: begin
					step <= step + 4'd1;
					if (step == LAST_STEP) begin
						state <= link_pkg::kb_hold_ack;
						knock_ack <= 1'b1;
					end
				end
				link_pkg::kb_hold_ack: begin
					if (!knock_req) begin // Early release
						state <= link_pkg::kb_idle;
						knock_ack <= 1'b0;
					end else begin
						state <= link_pkg::kb_wait_release;
					end
				end
				link_pkg::kb_wait_release: begin
					if (!knock_req) begin
						state <= link_pkg::kb_idle;
						knock_ack <= 1'b0;
					end
				end
			endcase
		end
	end

	// Divider datapath
	always_ff @(posedge clock) begin
		if (state == link_pkg::kb_idle && knock_req) begin
			acc_x <= {8'd0, prod_x};
			acc_y <= {8'd0, prod_y};
			neg_x <= knockback[31];
			neg_y <= knockback[15];
		end else if (state == link_pkg::kb_divide) begin
			acc_x <= acc_x_next;
			acc_y <= acc_y_next;
			if (step == LAST_STEP) begin
				kick.kick_x <= neg_x ? -quot_x : quot_x; // Truncates toward zero
				kick.kick_y <= neg_y ? -quot_y : quot_y;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/link_pkg.sv
`default_nettype none

// Layout of the words coming from the controller, the collision unit and the attack unit
package link_pkg;

	// Controller word
	localparam int JOY_W = 8;
	localparam int JOY_X_LSB = 8; // Bits 15 to 8
	localparam int JOY_Y_LSB = 0; // Bits 7 to 0
	localparam int JUMP_BIT = 24;

	// Stick zones on the Y axis
	localparam logic [JOY_W-1:0] DROP_MAX = 8'd15;
	localparam logic [JOY_W-1:0] JUMP_MIN = 8'd240;

	// Contact word bit indices
	localparam int WALL_UP = 0;
	localparam int WALL_DOWN = 1;
	localparam int WALL_RIGHT = 2;
	localparam int WALL_LEFT = 3;
	localparam int PLATFORM_DOWN = 4;

	// Knockback slave states
	typedef enum logic [1:0] {
		kb_idle,
		kb_divide,
		kb_hold_ack, // First ack cycle, kick strobe
		kb_wait_release
	} kb_state_e;

endpackage

`default_nettype wire

// File: logic/motion_integrator.sv
`timescale 1ns/1ps
`default_nettype none

module motion_integrator #(
	parameter int GRAVITY = 4,
	parameter int TICK_DIV = 8
) (
	input logic clock,
	input logic reset,
	input logic [31:0] start_position,
	input logic [4:0] contact,
	input logic freeze,
	intent_if.sink intent,
	knock_if.sink kick,
	output logic [31:0] position,
	output logic [31:0] velocity
);

	localparam int TICK_W = $clog2(TICK_DIV);
	localparam int FRAC_W = physics_pkg::FRAC_W;
	localparam int INT_W = physics_pkg::INT_W;

	logic [TICK_W-1:0] tick_count;
	logic tick;
	physics_pkg::motion_state_e state, state_next;
	logic jump_pending;
	physics_pkg::vel_t vel_x, vel_y;
	physics_pkg::pos_t pos_x, pos_y;
	logic grounded, block_x, block_y;

	assign tick = tick_count == TICK_W'(TICK_DIV - 1);

	// Stick down lets the player fall through a platform
	assign grounded = contact[link_pkg::WALL_DOWN] |
		(contact[link_pkg::PLATFORM_DOWN] & ~intent.drop_through);
	assign block_x = (vel_x > 0 && contact[link_pkg::WALL_RIGHT]) ||
		(vel_x < 0 && contact[link_pkg::WALL_LEFT]);
	assign block_y = vel_y > 0 && contact[link_pkg::WALL_UP];

	always_comb begin
		if (freeze)
			state_next = physics_pkg::st_frozen;
		else if (kick.kick || (state == physics_pkg::st_knocked && kick.busy))
			state_next = physics_pkg::st_knocked; // Hitstun lasts until release
		else if (grounded)
			state_next = physics_pkg::st_grounded;
		else
			state_next = physics_pkg::st_airborne;
	end

	always_ff @(posedge clock) begin
		if (reset)
			tick_count <= '0;
		else
			tick_count <= tick ? '0 : tick_count + TICK_W'(1);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= physics_pkg::st_grounded;
			jump_pending <= 1'b0;
			vel_x <= '0;
			vel_y <= '0;
		end else begin
			state <= state_next;
			case (state_next)
				physics_pkg::st_frozen: begin
					if (intent.jump)
						jump_pending <= 1'b1;
				end
				physics_pkg::st_knocked: begin
					jump_pending <= 1'b0;
					if (kick.kick) begin
						vel_x <= kick.kick_x;
						vel_y <= kick.kick_y;
					end
				end
				physics_pkg::st_grounded: begin
					if (tick) begin
						vel_x <= intent.move_x;
						vel_y <= (jump_pending | intent.jump) ? intent.jump_vel : '0;
						jump_pending <= 1'b0;
					end else if (intent.jump) begin
						jump_pending <= 1'b1;
					end
				end
				physics_pkg::st_airborne: begin
					if (tick) begin
						if (vel_x < intent.move_x)
							vel_x <= vel_x + 24'sd1; // Ease toward stick
						else if (vel_x > intent.move_x)
							vel_x <= vel_x - 24'sd1;
						vel_y <= vel_y - physics_pkg::vel_t'(GRAVITY);
						jump_pending <= 1'b0;
					end else if (intent.jump) begin
						jump_pending <= 1'b1;
					end
				end
			endcase
		end
	end

	// Position integrates every cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			pos_x <= {start_position[31:16], {FRAC_W{1'b0}}};
			pos_y <= {start_position[15:0], {FRAC_W{1'b0}}};
		end else if (!freeze) begin
			if (!block_x)
				pos_x <= pos_x + physics_pkg::pos_t'(vel_x);
			if (!block_y)
				pos_y <= pos_y + physics_pkg::pos_t'(vel_y);
		end
	end

	assign position = {pos_x[physics_pkg::POS_W-1 -: INT_W], pos_y[physics_pkg::POS_W-1 -: INT_W]};
	assign velocity = {vel_x[physics_pkg::VEL_W-1 -: physics_pkg::VEL_OUT_W],
		vel_y[physics_pkg::VEL_W-1 -: physics_pkg::VEL_OUT_W]};

endmodule

`default_nettype wire

// File: logic/physics_coprocessor.sv
`timescale 1ns/1ps
`default_nettype none

module physics_coprocessor #(
	parameter int MASS_SHIFT = 2,
	parameter int GRAVITY = 4,
	parameter int TICK_DIV = 8
) (
	input logic clock,
	input logic reset,
	input logic [31:0] controller,
	input logic [4:0] contact,       // Collision flags
	input logic freeze,
	input logic [31:0] start_position, // X over Y, integer parts
	input logic knock_req,
	input logic [31:0] knockback,
	input logic [15:0] damage,
	output logic knock_ack,
	output logic [31:0] position,
	output logic [31:0] velocity
);

	intent_if intent ();
	knock_if kick ();

	input_decoder #(
		.MASS_SHIFT(MASS_SHIFT)
	) u_decoder (
		.clock(clock),
		.reset(reset),
		.controller(controller),
		.contact(contact),
		.intent(intent)
	);

	knockback_calc u_knockback (
		.clock(clock),
		.reset(reset),
		.knock_req(knock_req),
		.knockback(knockback),
		.damage(damage),
		.knock_ack(knock_ack),
		.kick(kick)
	);

	motion_integrator #(
		.GRAVITY(GRAVITY),
		.TICK_DIV(TICK_DIV)
	) u_integrator (
		.clock(clock),
		.reset(reset),
		.start_position(start_position),
		.contact(contact),
		.freeze(freeze),
		.intent(intent),
		.kick(kick),
		.position(position),
		.velocity(velocity)
	);

endmodule

`default_nettype wire

// File: logic/physics_pkg.sv
`default_nettype none

// Fixed-point motion types shared by the datapath
package physics_pkg;

	// Position is 16.16 signed, one register per axis
	localparam int POS_W = 32;
	localparam int FRAC_W = 16;
	localparam int INT_W = POS_W - FRAC_W;

	// Velocity counts fraction units per clock
	localparam int VEL_W = 24;
	localparam int VEL_OUT_W = 16; // Top bits reported on the velocity port

	typedef logic signed [POS_W-1:0] pos_t;
	typedef logic signed [VEL_W-1:0] vel_t;

	// Player motion modes
	typedef enum logic [1:0] {
		st_grounded,
		st_airborne,
		st_knocked, // Hitstun, velocity held from the kick
		st_frozen
	} motion_state_e;

	// Upward jump velocity before the mass shift
	localparam vel_t JUMP_IMPULSE = 24'sh00_1000;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module physics_tb \
	-f sim.f -o physics_sim > build.log 2>&1 \
	&& ./obj_dir/physics_sim > sim.log 2>&1 \
	|| echo "RESULT: FAIL" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
exit 0

// File: sim.f
logic/physics_pkg.sv
logic/link_pkg.sv
logic/intent_if.sv
logic/knock_if.sv
logic/input_decoder.sv
logic/knockback_calc.sv
logic/motion_integrator.sv
logic/physics_coprocessor.sv
verif/physics_sva.sv
verif/physics_tb.sv

// File: verif/physics_sva.sv
`timescale 1ns/1ps
`default_nettype none

module physics_sva (
	input logic clock,
	input logic reset,
	input logic knock_req,
	input logic knock_ack,
	input logic kick_strobe,
	input logic freeze,
	input logic [31:0] position
);

	// Ack only answers a live request
	ack_needs_req: assert property (@(posedge clock) disable iff (reset)
		$rose(knock_ack) |-> knock_req)
		else $error("knock_ack rose with knock_req low");

	ack_held: assert property (@(posedge clock) disable iff (reset)
		knock_ack && knock_req |=> knock_ack)
		else $error("knock_ack dropped while knock_req was still high");

	kick_single: assert property (@(posedge clock) disable iff (reset)
		kick_strobe |=> !kick_strobe)
		else $error("kick strobe lasted more than one cycle");

	// Frozen player stays put
	freeze_holds: assert property (@(posedge clock) disable iff (reset)
		freeze |=> $stable(position))
		else $error("position changed while freeze was high");

endmodule

bind knockback_calc physics_sva u_handshake_sva (
	.clock(clock),
	.reset(reset),
	.knock_req(knock_req),
	.knock_ack(knock_ack),
	.kick_strobe(kick.kick),
	.freeze(1'b0),
	.position(32'h0)
);

bind motion_integrator physics_sva u_motion_sva (
	.clock(clock),
	.reset(reset),
	.knock_req(1'b0),
	.knock_ack(1'b0),
	.kick_strobe(kick.kick),
	.freeze(freeze),
	.position(position)
);

`default_nettype wire

// File: verif/physics_tb.sv
`timescale 1ns/1ps
`default_nettype none

module physics_tb;

	localparam int MASS_SHIFT = 2;
	localparam int GRAVITY = 4;
	localparam int TICK_DIV = 8;
	localparam int KICK_RUNS = 20;
	localparam int ACK_TIMEOUT = 40;
	localparam int HOLD_CYCLES = 24; // Longer than one full divide
	localparam int MOVE_CYCLES = 128; // Whole number of pixels at stick X 200
	localparam logic [31:0] START_POS = 32'h0064_0032; // X 100, Y 50
	localparam logic [4:0] ON_GROUND = 5'd1 << link_pkg::WALL_DOWN;
	localparam logic [4:0] RIGHT_WALL = 5'd1 << link_pkg::WALL_RIGHT;

	logic clock;
	logic reset;
	logic [31:0] controller;
	logic [4:0] contact;
	logic freeze;
	logic [31:0] start_position;
	logic knock_req;
	logic [31:0] knockback;
	logic [15:0] damage;
	logic knock_ack;
	logic [31:0] position;
	logic [31:0] velocity;

	integer seed;
	int errors, compare_errors, timeouts, cycles;
	logic check_armed;
	string check_name;
	logic [31:0] exp_velocity;
	logic [31:0] kb_value, held_position, held_velocity;
	logic [15:0] dmg_value, start_x, x_step, prev_y, jump_field;
	logic [23:0] kick_x, kick_y;
	logic signed [23:0] move_vel, jump_vel;

	physics_coprocessor #(
		.MASS_SHIFT(MASS_SHIFT),
		.GRAVITY(GRAVITY),
		.TICK_DIV(TICK_DIV)
	) dut (
		.clock(clock),
		.reset(reset),
		.controller(controller),
		.contact(contact),
		.freeze(freeze),
		.start_position(start_position),
		.knock_req(knock_req),
		.knockback(knockback),
		.damage(damage),
		.knock_ack(knock_ack),
		.position(position),
		.velocity(velocity)
	);

	always #10 clock = ~clock;

	// One signed half scaled by (damage + 100) / 100, truncated toward zero
	function automatic logic [23:0] expected_kick(input logic [15:0] half, input logic [15:0] dmg);
		longint prod;
		prod = longint'($signed(half)) * (longint'(dmg) + 100);
		return 24'(prod / 100);
	endfunction

	// Stick X recentred, moved into fraction units and divided by mass
	function automatic int expected_move(input int stick_x);
		return ((stick_x - 128) * 256) >>> MASS_SHIFT;
	endfunction

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic wait_ack(input logic level, input string what);
		int count;
		count = 0;
		do begin
			@(negedge clock);
			count++;
		end while (knock_ack !== level && count < ACK_TIMEOUT);
		if (knock_ack !== level) begin
			$display("Timeout: knock_ack did not %s within %0d cycles", what, ACK_TIMEOUT);
			timeouts++;
		end
	endtask

	// Compares the velocity word while armed, on the falling edge
	always @(negedge clock) begin
		if (check_armed && velocity !== exp_velocity) begin
			$display("FAIL %s: expected %h, actual %h", check_name, exp_velocity, velocity);
			compare_errors++;
		end
	end

	initial begin
		seed = 32'h38f4_1c5d;
		errors = 0;
		compare_errors = 0;
		timeouts = 0;
		check_armed = 1'b0;
		check_name = "";
		exp_velocity = '0;
		clock = 1'b0;
		reset = 1'b1;
		controller = 32'h0000_8080; // Stick centred
		contact = ON_GROUND;
		freeze = 1'b0;
		start_position = START_POS;
		knock_req = 1'b0;
		knockback = '0;
		damage = '0;
		move_vel = 24'(expected_move(200));
		jump_vel = physics_pkg::JUMP_IMPULSE >>> MASS_SHIFT;
		jump_field = jump_vel[23:8];

		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_word("reset position", START_POS, position);
		check_word("reset velocity", 32'h0, velocity);
		check_word("reset knock_ack", 32'h0, {31'h0, knock_ack});

		for (int i = 0; i < KICK_RUNS; i++) begin
			kb_value = $random(seed);
			dmg_value = 16'($unsigned($random(seed)) % 1000);
			kick_x = expected_kick(kb_value[31:16], dmg_value);
			kick_y = expected_kick(kb_value[15:0], dmg_value);
			@(posedge clock);
			knockback <= kb_value;
			damage <= dmg_value;
			knock_req <= 1'b1;
			wait_ack(1'b1, "rise");
			// Kick lands one edge after ack, then must hold while req stays high
			@(posedge clock);
			knockback <= ~kb_value; // A repeated transfer would land a different kick
			check_name = $sformatf("knockback %0d", i);
			exp_velocity = {kick_x[23:8], kick_y[23:8]};
			check_armed = 1'b1;
			repeat (HOLD_CYCLES) @(posedge clock);
			check_armed = 1'b0;
			knock_req <= 1'b0;
			wait_ack(1'b0, "fall");
		end

		@(posedge clock);
		controller <= {16'h0000, 8'd200, 8'd128};
		repeat (TICK_DIV + 2) @(posedge clock);
		check_name = "grounded move";
		exp_velocity = {move_vel[23:8], 16'h0000};
		check_armed = 1'b1;
		@(posedge clock);
		check_armed = 1'b0;
		@(negedge clock);
		start_x = position[31:16];
		x_step = 16'((int'(move_vel) * MOVE_CYCLES) >>> 16);
		repeat (MOVE_CYCLES) @(negedge clock);
		check_word("grounded position", {16'h0, start_x + x_step}, {16'h0, position[31:16]});

		@(posedge clock);
		freeze <= 1'b1;
		controller <= {16'h0000, 8'd56, 8'd128}; // Reversed stick, ignored while frozen
		@(posedge clock);
		@(negedge clock);
		held_position = position;
		held_velocity = velocity;
		repeat (50) begin
			@(negedge clock);
			check_word("freeze position", held_position, position);
			check_word("freeze velocity", held_velocity, velocity);
		end
		@(posedge clock);
		controller <= {16'h0000, 8'd200, 8'd128};
		@(posedge clock);
		freeze <= 1'b0;

		@(posedge clock);
		contact <= ON_GROUND | RIGHT_WALL;
		@(posedge clock);
		@(negedge clock);
		start_x = position[31:16];
		repeat (20) @(negedge clock);
		check_word("wall block", {16'h0, start_x}, {16'h0, position[31:16]});

		@(posedge clock);
		contact <= ON_GROUND;
		controller <= {7'd0, 1'b1, 8'd0, 8'd128, 8'd128}; // Jump button, stick centred
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (velocity[15:0] == 16'h0000 && cycles < 4 * TICK_DIV);
		if (velocity[15:0] == 16'h0000) begin
			$display("Timeout: no jump velocity after the jump press");
			timeouts++;
		end
		check_word("jump velocity", {16'h0000, jump_field}, velocity);

		// Leave the ground before the next tick
		@(posedge clock);
		contact <= '0;
		controller <= 32'h0000_8080;
		@(negedge clock);
		prev_y = velocity[15:0];
		for (int c = 0; c < 120; c++) begin
			@(posedge clock);
			controller[link_pkg::JUMP_BIT] <= (c >= 20 && c < 30); // Second press in the air
			@(negedge clock);
			if ($signed(velocity[15:0]) > $signed(prev_y)) begin
				$display("FAIL airborne vel_y: expected at most %h, actual %h", prev_y,
					velocity[15:0]);
				errors++;
			end
			prev_y = velocity[15:0];
		end
		if ($signed(velocity[15:0]) >= $signed(jump_field)) begin
			$display("FAIL gravity: expected below %h, actual %h", jump_field, velocity[15:0]);
			errors++;
		end

		$display("Checks done: %0d errors, %0d compare errors, %0d timeouts", errors,
			compare_errors, timeouts);
		if (errors == 0 && compare_errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
